// ==== bench/dts_rx_tests.txt ====
# name route(hex) delay(hex) misaligned run_len credit_interval credit_start
# expected_slips expected_overflow
lock   00e4 000 0  60 1 0  0 0
slip   00e4 000 12 90 1 0  8 0
route  001b 000 3  70 1 0  4 0
offset 001b 688 0  80 1 0  0 0
credit 00e4 000 0  90 1 40 0 1

// ==== vlog.f ====
rtl/dts_cfg_pkg.sv
rtl/dts_reg_pkg.sv
rtl/dts_frame_if.sv
rtl/dts_deformatter.sv
rtl/dts_regs.sv
rtl/dts_lane_route.sv
rtl/dts_credit_tx.sv
rtl/dts_rx_top.sv
bench/tb_clkgen.sv
bench/tb_dts_rx.sv

// ==== bench/tb_dts_rx.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_dts_rx import dts_cfg_pkg::*, dts_reg_pkg::*; ();

  localparam int NL        = DEF_NUM_LANES;
  localparam int CREDITS   = 4;
  localparam int QDEPTH    = 4;
  localparam int MAX_WORDS = 256;
  localparam int WORD_W    = NL * PAYLOAD_W;

  typedef struct {
    string name;
    int    route;
    int    delay;
    int    mis;        // Misaligned words per lane
    int    run_len;
    int    cr_int;
    int    cr_start;
    int    exp_slips;
    int    exp_ovf;
  } test_rec_t;

  logic                      gt_clkout;
  logic                      rst_n;
  logic                      restart;
  logic [NL*LANE_WORD_W-1:0] lane_words;
  logic                      credit;
  logic [REG_ADDR_W-1:0]     reg_addr;
  logic [REG_DATA_W-1:0]     reg_wdata;
  logic                      reg_we;
  wire  [NL-1:0]             slip;
  wire  [NL-1:0]             locked;
  wire  [REG_DATA_W-1:0]     reg_rdata;
  wire                       out_valid;
  wire  [WORD_W-1:0]         out_data;
  wire  [NL-1:0]             out_sec;

  test_rec_t         tests [$];
  logic              slip_at [MAX_WORDS];  // Word index that triggers a slip
  logic [WORD_W-1:0] q_data [$];           // Model of the output queue
  logic [NL-1:0]     q_sec [$];
  logic              exp_valid;
  logic [WORD_W-1:0] exp_data;
  logic [NL-1:0]     exp_sec;
  int                m_credits;
  int                err_cnt = 0;
  int                cycle_cnt = 0;
  int                cycle_limit = 0;

  tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(3)) i_clkgen (
    .restart_i (restart), .clk_o (gt_clkout), .rst_n_o (rst_n)
  );

  dts_rx_top #(.NUM_LANES(NL), .CREDITS(CREDITS), .QUEUE_DEPTH(QDEPTH)) i_dts_rx_top (
    .gt_clkout (gt_clkout), .rst_n_i (rst_n), .lane_words_i (lane_words),
    .credit_i (credit), .reg_addr_i (reg_addr), .reg_wdata_i (reg_wdata),
    .reg_we_i (reg_we), .slip_o (slip), .locked_o (locked), .reg_rdata_o (reg_rdata),
    .out_valid_o (out_valid), .out_data_o (out_data), .out_sec_o (out_sec)
  );

  task automatic check_value(input string sig, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
    end
  endtask

  function automatic logic [PAYLOAD_W-1:0] lane_payload(input int lane, input int k);
    return PAYLOAD_W'(lane * 4096 + k);
  endfunction

  function automatic logic [LANE_WORD_W-1:0] lane_word(input int lane, input int k,
                                                       input int mis);
    logic [MARK_W-1:0] mk;
    mk = (k % 16 == 0) ? MARK_SECOND : MARK_NORMAL;
    if (k < mis) begin
      mk = MARK_W'($urandom);
      while (mk == MARK_NORMAL || mk == MARK_SECOND) mk = MARK_W'($urandom);
    end
    return {mk, lane_payload(lane, k)};
  endfunction

  //////////////////////////////
  // Reference model
  task automatic plan_alignment(input int mis, output int lock_word);
    int hold;
    int good;
    hold      = 0;
    good      = 0;
    lock_word = MAX_WORDS;
    for (int k = 0; k < MAX_WORDS; k++) slip_at[k] = 1'b0;
    for (int k = 0; k < MAX_WORDS && lock_word == MAX_WORDS; k++) begin
      if (hold > 0) begin
        hold--;  // Markers ignored
        good = 0;
      end else if (k < mis) begin
        slip_at[k] = 1'b1;
        hold       = HOLDOFF;
        good       = 0;
      end else begin
        good++;
        if (good == LOCK_GOOD) lock_word = k;
      end
    end
  endtask

  // Predicts the edge after state c
  task automatic model_step(input test_rec_t t, input int c, input int first_valid);
    logic [WORD_W-1:0] jd;
    logic [NL-1:0]     js;
    logic              join_ok;
    int                w;
    int                src;
    join_ok = 1'b1;
    for (int j = 0; j < NL; j++) begin
      src = (t.route >> (j * ROUTE_SEL_W)) & ((1 << ROUTE_SEL_W) - 1);
      w   = c - 2 - ((t.delay >> (j * DELAY_W)) & ((1 << DELAY_W) - 1));
      if (w < first_valid) join_ok = 1'b0;
      jd[j*PAYLOAD_W +: PAYLOAD_W] = lane_payload(src, w);
      js[j] = (w % 16 == 0);
    end
    exp_valid = (q_data.size() > 0) && (m_credits > 0);
    if (exp_valid) begin
      exp_data = q_data.pop_front();
      exp_sec  = q_sec.pop_front();
      m_credits--;
    end
    if (credit) m_credits++;
    if (join_ok && q_data.size() < QDEPTH) begin  // Otherwise dropped
      q_data.push_back(jd);
      q_sec.push_back(js);
    end
  endtask

  //////////////////////////////
  // One test record
  task automatic run_test(input test_rec_t t, input bit first, output bit passed);
    int lock_word;
    int outstanding;
    int last_slip;
    int start_errs;
    start_errs = err_cnt;
    plan_alignment(t.mis, lock_word);
    q_data.delete();
    q_sec.delete();
    m_credits   = CREDITS;
    exp_valid   = 1'b0;
    outstanding = 0;
    last_slip   = -100;
    credit      = 1'b0;
    reg_we      = 1'b0;
    if (!first) begin
      restart = 1'b1;
      wait (rst_n == 1'b0);
      restart = 1'b0;
    end
    @(posedge rst_n);
    for (int c = 0; c < t.run_len; c++) begin
      if (c > 0) begin
        @(posedge gt_clkout);
        #10;
        check_value("locked_o", locked, (c > lock_word) ? {NL{1'b1}} : '0);
        check_value("slip_o", slip, slip_at[c-1] ? {NL{1'b1}} : '0);
        if (slip[0]) begin
          if (c - last_slip < HOLDOFF + 1) begin
            err_cnt++;
            $display("Slip pulses on lane 0 came only %0d cycles apart", c - last_slip);
          end
          last_slip = c;
        end
        check_value("out_valid_o", out_valid, exp_valid);
        if (exp_valid) begin
          check_value("out_data_o", out_data, exp_data);
          check_value("out_sec_o", out_sec, exp_sec);
        end
        if (out_valid) outstanding++;
        if (c == t.run_len - 4) check_value("REG_SLIPS", reg_rdata, t.exp_slips);
        if (c == t.run_len - 2) check_value("REG_SLIPS after clear", reg_rdata, 0);
        if (c == t.run_len - 1) check_value("REG_STATUS overflow", reg_rdata[STAT_OVF_BIT],
                                            t.exp_ovf);
      end
      for (int i = 0; i < NL; i++) begin
        lane_words[i*LANE_WORD_W +: LANE_WORD_W] = lane_word(i, c, t.mis);
      end
      // Receiver hands back one credit per received word
      credit = (c >= t.cr_start) && ((c - t.cr_start) % t.cr_int == 0) && (outstanding > 0);
      if (credit) outstanding--;
      reg_we    = (c < 2) || (c == t.run_len - 4);
      reg_addr  = (c == 0) ? REG_ROUTE : (c == 1) ? REG_DELAY : REG_SLIPS;
      reg_wdata = (c == 0) ? REG_DATA_W'(t.route) : REG_DATA_W'(t.delay);
      if (c == t.run_len - 2) reg_addr = REG_STATUS;
      model_step(t, c, lock_word + 1);
    end
    passed = (err_cnt == start_errs);
    if (passed) $display("Test %s finished, passed", t.name);
    else $display("Test %s finished with %0d mismatches", t.name, err_cnt - start_errs);
  endtask

  // Watchdog
  always @(posedge gt_clkout) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout, the run was stopped after %0d cycles", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int        fd;
    string     line;
    test_rec_t rec;
    int        pass_cnt;
    int        fail_cnt;
    bit        ok;
    void'($urandom(32'hb0031052));
    restart    = 1'b0;
    lane_words = '0;
    credit     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_we     = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    fd = $fopen("bench/dts_rx_tests.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%s %h %h %d %d %d %d %d %d", rec.name, rec.route, rec.delay,
                      rec.mis, rec.run_len, rec.cr_int, rec.cr_start, rec.exp_slips,
                      rec.exp_ovf) == 9) tests.push_back(rec);
        end
      end
      $fclose(fd);
    end
    if (tests.size() == 0) begin
      $display("No test records could be read from bench/dts_rx_tests.txt");
      $display("Errors found");
    end else begin
      foreach (tests[i]) cycle_limit += 2 * tests[i].run_len;
      cycle_limit += 200;
      foreach (tests[i]) begin
        run_test(tests[i], i == 0, ok);
        if (ok) pass_cnt++;
        else fail_cnt++;
      end
      $display("Tests passed %0d, failed %0d, mismatches %0d", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  input  wire  restart_i,
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset at time zero and again on each restart request
  initial begin
    rst_n_o = 1'b0;
    forever begin
      repeat (RST_CYCLES) @(posedge clk_o);
      #10 rst_n_o = 1'b1;  // Release just after an edge
      @(posedge restart_i);
      rst_n_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dts_rx_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module dts_rx_top import dts_cfg_pkg::*, dts_reg_pkg::*; #(
  parameter int NUM_LANES   = DEF_NUM_LANES,
  parameter int CREDITS     = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                             gt_clkout,
  input  wire                             rst_n_i,
  input  wire [NUM_LANES*LANE_WORD_W-1:0] lane_words_i,
  input  wire                             credit_i,
  input  wire [REG_ADDR_W-1:0]            reg_addr_i,
  input  wire [REG_DATA_W-1:0]            reg_wdata_i,
  input  wire                             reg_we_i,
  output wire [NUM_LANES-1:0]             slip_o,    // Gearbox slip per lane
  output wire [NUM_LANES-1:0]             locked_o,
  output wire [REG_DATA_W-1:0]            reg_rdata_o,
  output wire                             out_valid_o,
  output wire [NUM_LANES*PAYLOAD_W-1:0]   out_data_o,
  output wire [NUM_LANES-1:0]             out_sec_o
);

  wire [NUM_LANES*ROUTE_SEL_W-1:0] route_sel;
  wire [NUM_LANES*DELAY_W-1:0]     lane_delay;
  wire                             overflow;

  dts_frame_if def_fr [NUM_LANES] ();  // Deformatter outputs
  dts_frame_if rt_fr  [NUM_LANES] ();  // Routed and offset lanes

  //////////////////////////////
  // Per-lane deformatters
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    dts_deformatter i_deformatter (
      .gt_clkout   (gt_clkout),
      .rst_n_i     (rst_n_i),
      .lane_word_i (lane_words_i[i*LANE_WORD_W +: LANE_WORD_W]),
      .fr_o        (def_fr[i])
    );
    assign slip_o[i]   = def_fr[i].slip;
    assign locked_o[i] = def_fr[i].locked;
  end

  dts_regs #(.NUM_LANES(NUM_LANES)) i_regs (
    .gt_clkout (gt_clkout), .rst_n_i (rst_n_i),
    .reg_addr_i (reg_addr_i), .reg_wdata_i (reg_wdata_i), .reg_we_i (reg_we_i),
    .reg_rdata_o (reg_rdata_o), .lanes_i (def_fr), .overflow_i (overflow),
    .route_sel_o (route_sel), .lane_delay_o (lane_delay)
  );

  dts_lane_route #(.NUM_LANES(NUM_LANES)) i_lane_route (
    .gt_clkout (gt_clkout), .rst_n_i (rst_n_i), .in_i (def_fr),
    .route_sel_i (route_sel), .lane_delay_i (lane_delay), .out_o (rt_fr)
  );

  dts_credit_tx #(
    .NUM_LANES (NUM_LANES), .CREDITS (CREDITS), .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_credit_tx (
    .gt_clkout (gt_clkout), .rst_n_i (rst_n_i), .lanes_i (rt_fr), .credit_i (credit_i),
    .out_valid_o (out_valid_o), .out_data_o (out_data_o), .out_sec_o (out_sec_o),
    .overflow_o (overflow)
  );

endmodule

`default_nettype wire

// ==== rtl/dts_credit_tx.sv ====
`default_nettype none
`timescale 1ns/1ns

module dts_credit_tx import dts_cfg_pkg::*; #(
  parameter int NUM_LANES   = DEF_NUM_LANES,
  parameter int CREDITS     = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                            gt_clkout,
  input  wire                            rst_n_i,
  dts_frame_if.route                     lanes_i [NUM_LANES],
  input  wire                            credit_i,
  output logic                           out_valid_o,
  output logic [NUM_LANES*PAYLOAD_W-1:0] out_data_o,
  output logic [NUM_LANES-1:0]           out_sec_o,
  output logic                           overflow_o
);

  localparam int WORD_W = NUM_LANES * PAYLOAD_W;
  localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_W = $clog2(CREDITS + 1);

  logic [NUM_LANES-1:0] lane_valid;
  logic [WORD_W-1:0]    join_data;
  logic [NUM_LANES-1:0] join_sec;
  logic [WORD_W-1:0]    q_data [QUEUE_DEPTH];
  logic [NUM_LANES-1:0] q_sec  [QUEUE_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     q_cnt;
  logic [CRED_W-1:0]    credit_cnt;
  logic                 join_vld;
  logic                 send;
  logic                 push;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_join
    assign lane_valid[i]                      = lanes_i[i].valid;
    assign join_data[i*PAYLOAD_W +: PAYLOAD_W] = lanes_i[i].frame.payload;
    assign join_sec[i]                        = lanes_i[i].frame.sec;
  end

  assign join_vld = &lane_valid;
  assign send     = (q_cnt != '0) && (credit_cnt != '0);
  assign push     = join_vld && ((q_cnt != CNT_W'(QUEUE_DEPTH)) || send);  // Full unless popping

  always_ff @(posedge gt_clkout or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      q_cnt       <= '0;
      credit_cnt  <= CRED_W'(CREDITS);
      out_valid_o <= 1'b0;
      overflow_o  <= 1'b0;
    end else begin
      out_valid_o <= send;
      overflow_o  <= join_vld && !push;  // Word dropped
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (send) rd_ptr <= ptr_inc(rd_ptr);
      q_cnt <= q_cnt + CNT_W'(push) - CNT_W'(send);
      case ({send, credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: ;  // Send and return cancel
      endcase
    end
  end

  always_ff @(posedge gt_clkout) begin
    if (push) begin
      q_data[wr_ptr] <= join_data;
      q_sec[wr_ptr]  <= join_sec;
    end
    if (send) begin
      out_data_o <= q_data[rd_ptr];
      out_sec_o  <= q_sec[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dts_lane_route.sv ====
`default_nettype none
`timescale 1ns/1ns

module dts_lane_route import dts_cfg_pkg::*, dts_reg_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire                             gt_clkout,
  input  wire                             rst_n_i,
  dts_frame_if.route                      in_i [NUM_LANES],
  input  wire [NUM_LANES*ROUTE_SEL_W-1:0] route_sel_i,
  input  wire [NUM_LANES*DELAY_W-1:0]     lane_delay_i,
  dts_frame_if.deformatter                out_o [NUM_LANES]
);

  localparam int LINE_LEN = 1 << DELAY_W;  // Stage 0 is the crossbar register

  logic        in_valid  [NUM_LANES];
  lane_frame_t in_frame  [NUM_LANES];
  logic        v_line    [NUM_LANES][LINE_LEN];
  lane_frame_t f_line    [NUM_LANES][LINE_LEN];

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_in
    assign in_valid[i]  = in_i[i].valid;
    assign in_frame[i]  = in_i[i].frame;
  end

  //////////////////////////////
  // Crossbar and offset lines
  always_ff @(posedge gt_clkout or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int j = 0; j < NUM_LANES; j++) begin
        for (int s = 0; s < LINE_LEN; s++) v_line[j][s] <= 1'b0;
      end
    end else begin
      for (int j = 0; j < NUM_LANES; j++) begin
        v_line[j][0] <= in_valid[route_sel_i[j*ROUTE_SEL_W +: ROUTE_SEL_W]];
        for (int s = 1; s < LINE_LEN; s++) v_line[j][s] <= v_line[j][s-1];
      end
    end
  end

  always_ff @(posedge gt_clkout) begin
    for (int j = 0; j < NUM_LANES; j++) begin
      f_line[j][0] <= in_frame[route_sel_i[j*ROUTE_SEL_W +: ROUTE_SEL_W]];
      for (int s = 1; s < LINE_LEN; s++) f_line[j][s] <= f_line[j][s-1];
    end
  end

  for (genvar j = 0; j < NUM_LANES; j++) begin : g_out
    logic [DELAY_W-1:0] tap;
    assign tap             = lane_delay_i[j*DELAY_W +: DELAY_W];
    assign out_o[j].valid  = v_line[j][tap];
    assign out_o[j].frame  = f_line[j][tap];
    assign out_o[j].locked = 1'b0;  // Lock stays with the deformatter
    assign out_o[j].slip   = 1'b0;  // Slips stop at the deformatter
  end

endmodule

`default_nettype wire

// ==== rtl/dts_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module dts_regs import dts_cfg_pkg::*, dts_reg_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire                              gt_clkout,
  input  wire                              rst_n_i,
  input  wire  [REG_ADDR_W-1:0]            reg_addr_i,
  input  wire  [REG_DATA_W-1:0]            reg_wdata_i,
  input  wire                              reg_we_i,
  output logic [REG_DATA_W-1:0]            reg_rdata_o,
  dts_frame_if.regs                        lanes_i [NUM_LANES],
  input  wire                              overflow_i,
  output logic [NUM_LANES*ROUTE_SEL_W-1:0] route_sel_o,
  output logic [NUM_LANES*DELAY_W-1:0]     lane_delay_o
);

  localparam int ROUTE_W = NUM_LANES * ROUTE_SEL_W;
  localparam int DLY_W   = NUM_LANES * DELAY_W;

  logic [NUM_LANES-1:0]  lock_vec;
  logic [NUM_LANES-1:0]  slip_vec;
  logic [ROUTE_W-1:0]    route_q;
  logic [DLY_W-1:0]      delay_q;
  logic [SLIP_CNT_W-1:0] slip_cnt;
  logic [SLIP_CNT_W:0]   slip_sum;  // One extra bit to catch wrap
  logic                  ovf_q;
  logic [REG_DATA_W-1:0] status;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lock_vec[i] = lanes_i[i].locked;
    assign slip_vec[i] = lanes_i[i].slip;
  end

  assign slip_sum = {1'b0, slip_cnt} + (SLIP_CNT_W + 1)'($countones(slip_vec));

  always_comb begin
    status                  = '0;
    status[NUM_LANES-1:0]   = lock_vec;
    status[STAT_OVF_BIT]    = ovf_q;
  end

  always_ff @(posedge gt_clkout or negedge rst_n_i) begin
    if (!rst_n_i) begin
      route_q     <= ROUTE_RESET[ROUTE_W-1:0];
      delay_q     <= DELAY_RESET[DLY_W-1:0];
      slip_cnt    <= '0;
      ovf_q       <= 1'b0;
      reg_rdata_o <= '0;
    end else begin
      if (reg_we_i && reg_addr_i == REG_ROUTE) route_q <= reg_wdata_i[ROUTE_W-1:0];
      if (reg_we_i && reg_addr_i == REG_DELAY) delay_q <= reg_wdata_i[DLY_W-1:0];
      if (reg_we_i && reg_addr_i == REG_SLIPS) slip_cnt <= '0;
      else if (slip_sum[SLIP_CNT_W])           slip_cnt <= '1;  // Saturate
      else                                     slip_cnt <= slip_sum[SLIP_CNT_W-1:0];
      if (overflow_i)                               ovf_q <= 1'b1;
      else if (reg_we_i && reg_addr_i == REG_STATUS) ovf_q <= 1'b0;
      case (reg_addr_i)
        REG_ROUTE:  reg_rdata_o <= REG_DATA_W'(route_q);
        REG_DELAY:  reg_rdata_o <= REG_DATA_W'(delay_q);
        REG_STATUS: reg_rdata_o <= status;
        default:    reg_rdata_o <= slip_cnt;
      endcase
    end
  end

  assign route_sel_o  = route_q;
  assign lane_delay_o = delay_q;

endmodule

`default_nettype wire

// ==== rtl/dts_deformatter.sv ====
`default_nettype none
`timescale 1ns/1ns

module dts_deformatter import dts_cfg_pkg::*; (
  input  wire                   gt_clkout,
  input  wire                   rst_n_i,
  input  wire [LANE_WORD_W-1:0] lane_word_i,
  dts_frame_if.deformatter      fr_o
);

  localparam int GOOD_W = $clog2(LOCK_GOOD);
  localparam int BAD_W  = $clog2(LOCK_BAD);
  localparam int HOLD_W = $clog2(HOLDOFF + 1);

  logic [MARK_W-1:0] marker;
  logic              mark_good;
  logic [GOOD_W-1:0] good_cnt;
  logic [BAD_W-1:0]  bad_cnt;
  logic [HOLD_W-1:0] hold_cnt;
  logic              locked_q;
  logic              slip_q;
  logic              valid_q;
  lane_frame_t       frame_q;

  assign marker    = lane_word_i[LANE_WORD_W-1 -: MARK_W];
  assign mark_good = (marker == MARK_NORMAL) || (marker == MARK_SECOND);

  //////////////////////////////
  // Lock acquire and slip
  always_ff @(posedge gt_clkout or negedge rst_n_i) begin
    if (!rst_n_i) begin
      good_cnt <= '0;
      bad_cnt  <= '0;
      hold_cnt <= '0;
      locked_q <= 1'b0;
      slip_q   <= 1'b0;
    end else begin
      slip_q <= 1'b0;
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;  // Gearbox still settling
        good_cnt <= '0;
      end else if (!locked_q) begin
        if (mark_good) begin
          if (good_cnt == GOOD_W'(LOCK_GOOD - 1)) begin
            locked_q <= 1'b1;
            good_cnt <= '0;
          end else begin
            good_cnt <= good_cnt + 1'b1;
          end
        end else begin
          good_cnt <= '0;
          slip_q   <= 1'b1;
          hold_cnt <= HOLD_W'(HOLDOFF);
        end
      end else if (mark_good) begin
        bad_cnt <= '0;
      end else if (bad_cnt == BAD_W'(LOCK_BAD - 1)) begin
        locked_q <= 1'b0;  // Lost alignment
        bad_cnt  <= '0;
      end else begin
        bad_cnt <= bad_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge gt_clkout or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= locked_q && mark_good;
    end
  end

  always_ff @(posedge gt_clkout) begin
    frame_q.payload <= lane_word_i[PAYLOAD_W-1:0];
    frame_q.sec     <= (marker == MARK_SECOND);
  end

  assign fr_o.valid  = valid_q;
  assign fr_o.frame  = frame_q;
  assign fr_o.locked = locked_q;
  assign fr_o.slip   = slip_q;

endmodule

`default_nettype wire

// ==== rtl/dts_frame_if.sv ====
`default_nettype none
`timescale 1ns/1ns

// One lane's frame between pipeline stages
interface dts_frame_if import dts_cfg_pkg::*; ();

  logic        valid;   // Frame holds a good aligned word
  lane_frame_t frame;
  logic        locked;
  logic        slip;    // One-cycle gearbox slip request

  modport deformatter (output valid, output frame, output locked, output slip);

  modport route (input valid, input frame, input locked);

  modport regs (input locked, input slip);

endinterface

`default_nettype wire

// ==== rtl/dts_reg_pkg.sv ====
`default_nettype none

package dts_reg_pkg;

  localparam int REG_ADDR_W = 2;
  localparam int REG_DATA_W = 16;

  //////////////////////////////
  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_ROUTE  = 2'd0;
  localparam logic [REG_ADDR_W-1:0] REG_DELAY  = 2'd1;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 2'd2;  // Write clears overflow
  localparam logic [REG_ADDR_W-1:0] REG_SLIPS  = 2'd3;  // Write clears count

  localparam int ROUTE_SEL_W  = 2;  // Input lane select per output lane
  localparam int DELAY_W      = 3;  // Offset delay per lane, 0 to 7
  localparam int STAT_OVF_BIT = 4;
  localparam int SLIP_CNT_W   = 16;

  localparam logic [REG_DATA_W-1:0] ROUTE_RESET = 16'h00E4;  // Identity
  localparam logic [REG_DATA_W-1:0] DELAY_RESET = 16'h0000;

endpackage

`default_nettype wire

// ==== rtl/dts_cfg_pkg.sv ====
`default_nettype none

package dts_cfg_pkg;

  //////////////////////////////
  // Lane word format
  localparam int DEF_NUM_LANES = 4;
  localparam int PAYLOAD_W     = 16;
  localparam int MARK_W        = 4;
  localparam int LANE_WORD_W   = MARK_W + PAYLOAD_W;  // Marker nibble on top

  localparam logic [MARK_W-1:0] MARK_NORMAL = 4'hA;
  localparam logic [MARK_W-1:0] MARK_SECOND = 4'hB;  // Aligned word with second tick

  //////////////////////////////
  // Alignment tracking
  localparam int LOCK_GOOD = 4;  // Good markers in a row to lock
  localparam int LOCK_BAD  = 2;  // Bad markers in a row to drop lock
  localparam int HOLDOFF   = 8;  // Cycles ignored after a slip

  // One lane's frame after deformatting
  typedef struct packed {
    logic [PAYLOAD_W-1:0] payload;
    logic                 sec;
  } lane_frame_t;

endpackage

`default_nettype wire
